// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= ira_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/ira_tb.sv ====
`timescale 1ns/10ps

module ira_tb;
  import ira_mem_pkg::*;
  import ira_cmd_pkg::*;

  localparam int          N_ENTRIES  = 64;
  localparam int          RD_LAT     = 2;
  localparam int          TIMER_MAX  = 2**6 - 1;
  localparam int          N_TESTS    = 6;
  localparam int          ACK_LIMIT  = 8;
  localparam int          POLL_LIMIT = 200;
  localparam logic [15:0] CMND_ADR   = 16'h0;
  localparam logic [15:0] STAT_ADR   = 16'h4;
  localparam logic [15:0] DATA_ADR   = 16'h8;
  localparam logic [15:0] CAP_ADR    = 16'hc;

  logic        clk;
  logic        rst_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [15:0] wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;
  mem_req_t    hw_req;
  logic [31:0] hw_dout;
  logic        hw_yield;

  logic [31:0] ref_mem [N_ENTRIES]; // mirror of every write.
  int          errors;
  int          tests_passed;
  int          tests_failed;

  ira_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ##############################
  // bus and port tasks
  // ##############################

  // starts and returns on a falling edge.
  task automatic wb_access(input logic we, input logic [15:0] adr, input logic [31:0] wdat,
                           output logic [31:0] rdat);
    int n;
    n        = 0;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdat;
    do begin
      @(negedge clk);
      n++;
    end while (!wb_ack && n < ACK_LIMIT);
    assert (wb_ack) else begin
      $display("error: no Wishbone ack for address %h", adr);
      errors++;
    end
    rdat   = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input logic [15:0] adr, input logic [31:0] data);
    logic [31:0] unused;
    wb_access(1'b1, adr, data, unused);
  endtask

  task automatic wb_read(input logic [15:0] adr, output logic [31:0] data);
    wb_access(1'b0, adr, 32'h0, data);
  endtask

  task automatic hw_write(input logic [9:0] addr, input logic [31:0] data);
    hw_req = '{cs: 1'b1, we: 1'b1, re: 1'b0, waddr: addr, raddr: '0, wdata: data};
    @(negedge clk);
    hw_req = '0;
  endtask

  task automatic hw_read(input logic [9:0] addr, output logic [31:0] data);
    hw_req = '{cs: 1'b1, we: 1'b0, re: 1'b1, waddr: '0, raddr: addr, wdata: '0};
    @(negedge clk);
    hw_req = '0;
    repeat (RD_LAT - 1) @(negedge clk);
    data = hw_dout;
  endtask

  task automatic wait_done(output logic [2:0] code, output logic [9:0] addr);
    logic [31:0] word;
    int          polls;
    polls = 0;
    @(negedge clk); // status turns busy a cycle after the pulse.
    do begin
      wb_read(STAT_ADR, word);
      polls++;
    end while (word[30:28] == ST_BUSY && polls < POLL_LIMIT);
    assert (word[30:28] != ST_BUSY) else begin
      $display("error: command still busy after %0d status polls", polls);
      errors++;
    end
    code = word[30:28];
    addr = word[9:0];
  endtask

  // ##############################
  // checks and commands
  // ##############################

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    assert (got === exp) else begin
      $display("FAIL @%0t: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic issue_cmd(input logic [3:0] op, input logic [9:0] addr,
                           input logic [2:0] exp_code);
    logic [2:0] code;
    logic [9:0] st_addr;
    wb_write(CMND_ADR, {op, 18'h0, addr});
    wait_done(code, st_addr);
    check_eq(32'(code), 32'(exp_code), $sformatf("status of op %0h", op));
    check_eq(32'(st_addr), 32'(addr), "status address");
  endtask

  task automatic sw_write(input logic [9:0] addr, input logic [31:0] data);
    wb_write(DATA_ADR, data);
    issue_cmd(OP_WRITE, addr, ST_OK);
    ref_mem[addr] = data;
  endtask

  task automatic sw_read(input logic [9:0] addr, output logic [31:0] data);
    issue_cmd(OP_READ, addr, ST_OK);
    wb_read(DATA_ADR, data);
  endtask

  task automatic end_test(input string name, input int err_start);
    if (errors == err_start) begin
      tests_passed++;
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - err_start);
    end
  endtask

  // ##############################
  // tests
  // ##############################

  task automatic test_reset_cap();
    int          e0;
    logic [31:0] word;
    logic [15:0] ops;
    e0  = errors;
    ops = 16'((1 << OP_READ) | (1 << OP_WRITE) | (1 << OP_INIT));
    wb_read(STAT_ADR, word);
    check_eq(32'(word[30:28]), 32'(ST_IDLE), "status after reset");
    check_eq(32'(hw_yield), 32'h0, "hw_yield after reset");
    wb_read(CAP_ADR, word);
    check_eq(word, {12'h0, 4'(RAM_1R1W), ops}, "capability");
    wb_read(16'h10, word);
    check_eq(word, 32'h0, "unmapped offset");
    end_test("reset_cap", e0);
  endtask

  task automatic test_write_read();
    int          e0;
    logic [9:0]  addr [8];
    logic [31:0] got;
    e0 = errors;
    foreach (addr[i]) begin
      addr[i] = 10'((i * 7 + 3) % N_ENTRIES);
      sw_write(addr[i], $urandom);
    end
    foreach (addr[i]) begin
      sw_read(addr[i], got);
      check_eq(got, ref_mem[addr[i]], $sformatf("read of entry %0d", addr[i]));
    end
    end_test("write_read", e0);
  endtask

  task automatic test_init();
    int          e0;
    logic [31:0] fill;
    logic [31:0] got;
    e0   = errors;
    fill = $urandom;
    wb_write(DATA_ADR, fill);
    issue_cmd(OP_INIT, 10'd0, ST_OK);
    for (int i = 0; i < N_ENTRIES; i++) begin
      ref_mem[i] = fill;
      hw_read(10'(i), got);
      check_eq(got, fill, $sformatf("init entry %0d", i));
    end
    end_test("init", e0);
  endtask

  task automatic test_errors();
    int          e0;
    logic [31:0] got;
    e0 = errors;
    wb_write(DATA_ADR, ~ref_mem[36]);
    issue_cmd(OP_WRITE, 10'd100, ST_ERR); // aliases entry 36 if decoded wrong.
    issue_cmd(4'hf, 10'd5, ST_ERR);
    issue_cmd(OP_NOP, 10'd6, ST_ERR);
    hw_read(10'd36, got);
    check_eq(got, ref_mem[36], "entry 36 after range error");
    sw_read(10'd5, got);
    check_eq(got, ref_mem[5], "entry 5 after bad opcode");
    hw_read(10'd6, got);
    check_eq(got, ref_mem[6], "entry 6 after nop");
    end_test("errors", e0);
  endtask

  task automatic test_priority_timeout();
    int          e0;
    logic [31:0] word;
    logic [2:0]  code;
    logic [9:0]  addr;
    e0        = errors;
    hw_req    = '0;
    hw_req.cs = 1'b1; // port held without an access.
    wb_write(CMND_ADR, {OP_READ, 18'h0, 10'd7});
    repeat (8) @(negedge clk);
    wb_read(STAT_ADR, word);
    check_eq(32'(word[30:28]), 32'(ST_BUSY), "status while held");
    check_eq(32'(hw_yield), 32'h1, "hw_yield while held");
    hw_req.cs = 1'b0;
    wait_done(code, addr);
    check_eq(32'(code), 32'(ST_OK), "status after release");
    check_eq(32'(hw_yield), 32'h0, "hw_yield after release");
    wb_read(DATA_ADR, word);
    check_eq(word, ref_mem[7], "read after release");
    hw_req.cs = 1'b1;
    wb_write(CMND_ADR, {OP_READ, 18'h0, 10'd9});
    repeat (TIMER_MAX) @(negedge clk);
    wait_done(code, addr);
    check_eq(32'(code), 32'(ST_TIMEOUT), "status past timer limit");
    check_eq(32'(hw_yield), 32'h0, "hw_yield after timeout");
    hw_req.cs = 1'b0;
    end_test("priority_timeout", e0);
  endtask

  task automatic test_shared();
    int          e0;
    logic [9:0]  addr [4];
    logic [31:0] data;
    logic [31:0] got;
    e0 = errors;
    foreach (addr[i]) begin
      addr[i] = 10'($urandom_range(N_ENTRIES - 1));
      data    = $urandom;
      hw_write(addr[i], data);
      ref_mem[addr[i]] = data;
    end
    foreach (addr[i]) begin
      sw_read(addr[i], got);
      check_eq(got, ref_mem[addr[i]], $sformatf("software view of entry %0d", addr[i]));
    end
    sw_write(addr[0], $urandom);
    hw_read(addr[0], got);
    check_eq(got, ref_mem[addr[0]], "hardware view of software write");
    end_test("shared", e0);
  endtask

  // ##############################
  // sequence and watchdog
  // ##############################

  initial begin
    void'($urandom(20839));
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    rst_n        = 1'b0;
    wb_cyc       = 1'b0;
    wb_stb       = 1'b0;
    wb_we        = 1'b0;
    wb_adr       = '0;
    wb_dat_w     = '0;
    hw_req       = '0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    test_reset_cap();
    test_write_read();
    test_init();
    test_errors();
    test_priority_timeout();
    test_shared();
    $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    repeat (N_TESTS * 2000) @(posedge clk);
    $display("timeout: tests did not finish within %0d cycles", N_TESTS * 2000);
    $display("Simulation failed");
    $finish;
  end

endmodule

// ==== src.f ====
verilog/ira_mem_pkg.sv
verilog/ira_cmd_pkg.sv
verilog/ira_reg_slave.sv
verilog/ira_cmd_ctrl.sv
verilog/ira_port_arbiter.sv
verilog/ira_ram_1r1w.sv
verilog/ira_top.sv
dv/ira_tb.sv

// ==== verilog/ira_cmd_ctrl.sv ====
`timescale 1ns/10ps

module ira_cmd_ctrl #(
  parameter int N_ENTRIES    = 64,
  parameter int N_TIMER_BITS = 6
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               cmd_valid,
  input  ira_cmd_pkg::cmd_t                  cmd,
  input  logic [ira_mem_pkg::MEM_DATA_W-1:0] wr_data,
  output ira_cmd_pkg::stat_t                 stat,
  output logic                               rd_load,
  output logic [ira_mem_pkg::MEM_DATA_W-1:0] rd_data,
  output ira_cmd_pkg::sw_req_t               sw_req,
  input  logic                               grant,
  input  logic                               rsp_valid,
  input  logic [ira_mem_pkg::MEM_DATA_W-1:0] rsp_data
);
  import ira_cmd_pkg::*;
  import ira_mem_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_CHECK,
    S_REQ,
    S_WAIT_RSP,
    S_INIT_SWEEP
  } state_e;

  localparam logic [MEM_ADDR_W-1:0] LAST_ADDR = MEM_ADDR_W'(N_ENTRIES - 1);

  state_e                  state;
  cmd_t                    cmd_q;
  logic [N_TIMER_BITS-1:0] timer;
  logic                    accept;
  logic                    timer_done;
  logic                    last_entry;

  assign accept     = cmd_valid && (stat.code != ST_BUSY); // busy drops it.
  assign timer_done = (timer == {N_TIMER_BITS{1'b1}});
  assign last_entry = (sw_req.addr == LAST_ADDR);

  // read data goes straight into the data register.
  assign rd_load = (state == S_WAIT_RSP) && rsp_valid;
  assign rd_data = rsp_data;

  always_ff @(posedge clk) begin
    if (state == S_IDLE && accept) begin
      cmd_q <= cmd;
    end
  end

  // ##############################
  // command FSM
  // ##############################

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= S_IDLE;
      stat   <= '{code: ST_IDLE, addr: '0};
      sw_req <= '0;
      timer  <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (accept) begin
            stat  <= '{code: ST_BUSY, addr: cmd.addr};
            state <= S_CHECK;
          end
        end
        S_CHECK: begin
          timer <= '0;
          case (cmd_q.op)
            OP_READ, OP_WRITE: begin
              if (cmd_q.addr >= N_ENTRIES) begin
                stat.code <= ST_ERR;
                state     <= S_IDLE;
              end else begin
                sw_req <= '{valid: 1'b1, we: (cmd_q.op == OP_WRITE),
                            addr: cmd_q.addr, wdata: wr_data};
                state  <= S_REQ;
              end
            end
            OP_INIT: begin
              sw_req <= '{valid: 1'b1, we: 1'b1, addr: '0, wdata: wr_data};
              state  <= S_INIT_SWEEP;
            end
            default: begin
              stat.code <= ST_ERR; // nop and unknown opcodes.
              state     <= S_IDLE;
            end
          endcase
        end
        S_REQ: begin
          if (grant) begin
            sw_req.valid <= 1'b0;
            if (sw_req.we) begin
              stat.code <= ST_OK;
              state     <= S_IDLE;
            end else begin
              state <= S_WAIT_RSP;
            end
          end else if (timer_done) begin
            sw_req.valid <= 1'b0;
            stat.code    <= ST_TIMEOUT;
            state        <= S_IDLE;
          end else begin
            timer <= timer + 1'b1;
          end
        end
        S_WAIT_RSP: begin
          if (rsp_valid) begin
            stat.code <= ST_OK;
            state     <= S_IDLE;
          end
        end
        S_INIT_SWEEP: begin
          if (grant) begin
            timer <= '0; // each written entry restarts the wait.
            if (last_entry) begin
              sw_req.valid <= 1'b0;
              stat.code    <= ST_OK;
              state        <= S_IDLE;
            end else begin
              sw_req.addr <= sw_req.addr + 1'b1;
            end
          end else if (timer_done) begin
            sw_req.valid <= 1'b0;
            stat         <= '{code: ST_TIMEOUT, addr: sw_req.addr};
            state        <= S_IDLE;
          end else begin
            timer <= timer + 1'b1;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

// ==== verilog/ira_cmd_pkg.sv ====
package ira_cmd_pkg;

  // ##############################
  // commands and status
  // ##############################

  typedef enum logic [3:0] {
    OP_NOP   = 4'h0,
    OP_READ  = 4'h1,
    OP_WRITE = 4'h2,
    OP_INIT  = 4'h3
  } cmd_op_e;

  typedef enum logic [2:0] {
    ST_IDLE    = 3'd0,
    ST_OK      = 3'd1,
    ST_ERR     = 3'd2,
    ST_TIMEOUT = 3'd3,
    ST_BUSY    = 3'd4
  } stat_code_e;

  typedef struct packed {
    cmd_op_e                              op;
    logic [ira_mem_pkg::MEM_ADDR_W-1:0]   addr;
  } cmd_t;

  typedef struct packed {
    stat_code_e                           code;
    logic [ira_mem_pkg::MEM_ADDR_W-1:0]   addr;
  } stat_t;

  // controller request toward the arbiter.
  typedef struct packed {
    logic                                 valid;
    logic                                 we;
    logic [ira_mem_pkg::MEM_ADDR_W-1:0]   addr;
    logic [ira_mem_pkg::MEM_DATA_W-1:0]   wdata;
  } sw_req_t;

  // bit n set means opcode n is supported.
  localparam logic [15:0] CAP_OPS = 16'h000e;

  // ##############################
  // register words
  // ##############################

  typedef struct packed {
    cmd_op_e                                op;     // [31:28]
    logic [27-ira_mem_pkg::MEM_ADDR_W:0]    rsvd;
    logic [ira_mem_pkg::MEM_ADDR_W-1:0]     addr;
  } cmd_reg_t;

  typedef struct packed {
    logic                                   rsvd_hi;
    stat_code_e                             code;   // [30:28]
    logic [27-ira_mem_pkg::MEM_ADDR_W:0]    rsvd;
    logic [ira_mem_pkg::MEM_ADDR_W-1:0]     addr;
  } stat_reg_t;

  typedef struct packed {
    logic [11:0] rsvd;
    logic [3:0]  kind;
    logic [15:0] ops;
  } cap_reg_t;

endpackage

// ==== verilog/ira_mem_pkg.sv ====
package ira_mem_pkg;

  // ##############################
  // widths
  // ##############################

  localparam int MEM_DATA_W = 32;
  localparam int MEM_ADDR_W = 10; // up to 1024 entries.

  // ##############################
  // memory port
  // ##############################

  // one request per cycle, separate read and write addresses.
  typedef struct packed {
    logic                  cs;
    logic                  we;
    logic                  re;
    logic [MEM_ADDR_W-1:0] waddr;
    logic [MEM_ADDR_W-1:0] raddr;
    logic [MEM_DATA_W-1:0] wdata;
  } mem_req_t;

  // reported through the capability register.
  typedef enum logic [3:0] {
    RAM_1R1W = 4'h1,
    RAM_1RW  = 4'h2
  } mem_kind_e;

endpackage

// ==== verilog/ira_port_arbiter.sv ====
`timescale 1ns/10ps

module ira_port_arbiter #(
  parameter int RD_LATENCY = 2
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  ira_mem_pkg::mem_req_t hw_req,
  input  ira_cmd_pkg::sw_req_t  sw_req,
  output logic                  grant,
  output logic                  hw_yield,
  output ira_mem_pkg::mem_req_t mem_req,
  output logic                  rsp_valid
);
  import ira_cmd_pkg::*;
  import ira_mem_pkg::*;

  logic                  sw_rd_go;
  logic [RD_LATENCY-1:0] rd_pipe; // one bit per read in flight.

  assign grant    = !hw_req.cs; // hardware always wins.
  assign hw_yield = sw_req.valid && hw_req.cs;
  assign sw_rd_go = grant && sw_req.valid && !sw_req.we;

  always_comb begin
    if (hw_req.cs) begin
      mem_req = hw_req;
    end else begin
      mem_req.cs    = sw_req.valid;
      mem_req.we    = sw_req.valid && sw_req.we;
      mem_req.re    = sw_req.valid && !sw_req.we;
      mem_req.waddr = sw_req.addr;
      mem_req.raddr = sw_req.addr;
      mem_req.wdata = sw_req.wdata;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_pipe <= '0;
    end else begin
      rd_pipe <= (rd_pipe << 1) | RD_LATENCY'(sw_rd_go);
    end
  end

  assign rsp_valid = rd_pipe[RD_LATENCY-1];

endmodule

// ==== verilog/ira_ram_1r1w.sv ====
`timescale 1ns/10ps

module ira_ram_1r1w #(
  parameter int N_ENTRIES  = 64,
  parameter int RD_LATENCY = 2
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  ira_mem_pkg::mem_req_t              mem_req,
  output logic [ira_mem_pkg::MEM_DATA_W-1:0] rdata
);
  import ira_mem_pkg::*;

  localparam int IDX_W = (N_ENTRIES > 1) ? $clog2(N_ENTRIES) : 1;

  logic [MEM_DATA_W-1:0] mem      [N_ENTRIES];
  logic [MEM_DATA_W-1:0] rd_stage [RD_LATENCY];

  // write port.
  always_ff @(posedge clk) begin
    if (mem_req.cs && mem_req.we && (mem_req.waddr < N_ENTRIES)) begin
      mem[mem_req.waddr[IDX_W-1:0]] <= mem_req.wdata;
    end
  end

  // ##############################
  // read pipeline
  // ##############################

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_stage <= '{default: '0};
    end else begin
      if (mem_req.cs && mem_req.re) begin
        rd_stage[0] <= mem[mem_req.raddr[IDX_W-1:0]];
      end
      for (int i = 1; i < RD_LATENCY; i++) begin
        rd_stage[i] <= rd_stage[i-1];
      end
    end
  end

  assign rdata = rd_stage[RD_LATENCY-1];

endmodule

// ==== verilog/ira_reg_slave.sv ====
`timescale 1ns/10ps

module ira_reg_slave #(
  parameter logic [15:0]           CMND_ADDRESS = 16'h0,
  parameter logic [15:0]           STAT_ADDRESS = 16'h4,
  parameter logic [15:0]           DATA_ADDRESS = 16'h8,
  parameter logic [15:0]           CAP_ADDRESS  = 16'hc,
  parameter ira_mem_pkg::mem_kind_e MEM_KIND    = ira_mem_pkg::RAM_1R1W
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               wb_cyc,
  input  logic                               wb_stb,
  input  logic                               wb_we,
  input  logic [15:0]                        wb_adr,
  input  logic [31:0]                        wb_dat_w,
  output logic [31:0]                        wb_dat_r,
  output logic                               wb_ack,
  output logic                               cmd_valid,
  output ira_cmd_pkg::cmd_t                  cmd,
  input  ira_cmd_pkg::stat_t                 stat,
  input  logic                               rd_load,
  input  logic [ira_mem_pkg::MEM_DATA_W-1:0] rd_data,
  output logic [ira_mem_pkg::MEM_DATA_W-1:0] wr_data
);
  import ira_cmd_pkg::*;
  import ira_mem_pkg::*;

  logic        access;
  logic        wr_acc;
  logic [15:0] adr_w;
  cmd_reg_t    cmd_word;
  stat_reg_t   stat_word;
  cap_reg_t    cap_word;
  logic [31:0] rd_mux;

  assign access = wb_cyc && wb_stb && !wb_ack; // first cycle of a transfer.
  assign wr_acc = access && wb_we;
  assign adr_w  = {wb_adr[15:2], 2'b00};

  assign cmd_word  = cmd_reg_t'(wb_dat_w);
  assign stat_word = '{rsvd_hi: 1'b0, code: stat.code, rsvd: '0, addr: stat.addr};
  assign cap_word  = '{rsvd: '0, kind: MEM_KIND, ops: CAP_OPS};

  // read decode.
  always_comb begin
    case (adr_w)
      CMND_ADDRESS: rd_mux = {cmd.op, {(28-MEM_ADDR_W){1'b0}}, cmd.addr};
      STAT_ADDRESS: rd_mux = stat_word;
      DATA_ADDRESS: rd_mux = wr_data;
      CAP_ADDRESS:  rd_mux = cap_word;
      default:      rd_mux = '0;
    endcase
  end

  // ##############################
  // ack, command and data register
  // ##############################

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_ack    <= 1'b0;
      cmd_valid <= 1'b0;
      cmd       <= '0;
      wr_data   <= '0;
    end else begin
      wb_ack    <= access;
      cmd_valid <= wr_acc && (adr_w == CMND_ADDRESS);
      if (wr_acc && (adr_w == CMND_ADDRESS)) begin
        cmd <= '{op: cmd_word.op, addr: cmd_word.addr};
      end
      if (rd_load) begin
        wr_data <= rd_data; // memory read beats a bus write.
      end else if (wr_acc && (adr_w == DATA_ADDRESS)) begin
        wr_data <= wb_dat_w;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      wb_dat_r <= rd_mux; // held during ack.
    end
  end

endmodule

// ==== verilog/ira_top.sv ====
`timescale 1ns/10ps

module ira_top #(
  parameter int                     N_ENTRIES    = 64,
  parameter int                     RD_LATENCY   = 2,
  parameter int                     N_TIMER_BITS = 6,
  parameter logic [15:0]            CMND_ADDRESS = 16'h0,
  parameter logic [15:0]            STAT_ADDRESS = 16'h4,
  parameter logic [15:0]            DATA_ADDRESS = 16'h8,
  parameter logic [15:0]            CAP_ADDRESS  = 16'hc,
  parameter ira_mem_pkg::mem_kind_e MEM_KIND     = ira_mem_pkg::RAM_1R1W
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               wb_cyc,
  input  logic                               wb_stb,
  input  logic                               wb_we,
  input  logic [15:0]                        wb_adr,
  input  logic [31:0]                        wb_dat_w,
  output logic [31:0]                        wb_dat_r,
  output logic                               wb_ack,
  input  ira_mem_pkg::mem_req_t              hw_req,
  output logic [ira_mem_pkg::MEM_DATA_W-1:0] hw_dout,
  output logic                               hw_yield
);
  import ira_cmd_pkg::*;
  import ira_mem_pkg::*;

  logic                  cmd_valid;
  cmd_t                  cmd;
  stat_t                 stat;
  logic                  rd_load;
  logic [MEM_DATA_W-1:0] rd_data;
  logic [MEM_DATA_W-1:0] wr_data;
  sw_req_t               sw_req;
  logic                  grant;
  logic                  rsp_valid;
  mem_req_t              mem_req;
  logic [MEM_DATA_W-1:0] rdata;

  assign hw_dout = rdata; // shared with the software response.

  ira_reg_slave #(
    .CMND_ADDRESS (CMND_ADDRESS),
    .STAT_ADDRESS (STAT_ADDRESS),
    .DATA_ADDRESS (DATA_ADDRESS),
    .CAP_ADDRESS  (CAP_ADDRESS),
    .MEM_KIND     (MEM_KIND)
  ) u_slave (.*);

  ira_cmd_ctrl #(
    .N_ENTRIES    (N_ENTRIES),
    .N_TIMER_BITS (N_TIMER_BITS)
  ) u_ctrl (.*, .rsp_data(rdata));

  ira_port_arbiter #(.RD_LATENCY(RD_LATENCY)) u_arb (.*);

  ira_ram_1r1w #(
    .N_ENTRIES  (N_ENTRIES),
    .RD_LATENCY (RD_LATENCY)
  ) u_ram (.*);

endmodule
